/* design/pipe_defs.svh */
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// Datapath and instruction width
`define XLEN 32

// Architectural register count
`define NREGS 32

// Instruction memory index bits for 64 words
`define IMEM_AW 6

// Data memory index bits for 64 words
`define DMEM_AW 6

`endif

/* design/pipePkg.sv */
`default_nettype none

`include "pipe_defs.svh"

package pipePkg;

	// Basic vectors
	typedef logic [`XLEN-1:0] word_t;
	typedef logic [$clog2(`NREGS)-1:0] regAddr_t;
	typedef logic [`IMEM_AW-1:0] pc_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// ALU operation select
	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} aluOp_t;

	// Execute operand source
	typedef enum logic [1:0] {FWD_NONE, FWD_WB, FWD_MEM} fwd_t;

	// --------------------------------------------------
	// MIPS32 opcode and funct values
	// --------------------------------------------------
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_ADDI = 6'h08;
	localparam opcode_t OP_LW = 6'h23;
	localparam opcode_t OP_SW = 6'h2b;
	localparam opcode_t OP_BEQ = 6'h04;
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR = 6'h25;
	localparam funct_t FN_SLT = 6'h2a;

endpackage

`default_nettype wire

/* design/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defs.svh"

module fetchUnit import pipePkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  run,
	input  logic  stallD,
	input  logic  branchTaken,
	input  pc_t   branchTarget,
	input  logic  stallF,
	input  logic  loadReq,
	input  pc_t   loadAddr,
	input  word_t loadData,
	output logic  loadAck,
	output word_t instrD,
	output pc_t   pcPlus1D
);

	typedef enum logic [1:0] {LD_IDLE, LD_ACK, LD_WAIT} ldState_t;

	ldState_t ldState;
	logic loadWe;
	logic runF;
	pc_t pcF;
	word_t imem [0:(1 << `IMEM_AW)-1];

	// --------------------------------------------------
	// Program load handshake
	// --------------------------------------------------

	// Word captured on the edge that sees the request, only while halted
	assign loadWe = (ldState == LD_IDLE) && loadReq && !run;
	assign loadAck = (ldState == LD_ACK);

	always_ff @(posedge clk)
	begin
		if (rst)
			ldState <= LD_IDLE;
		else
		begin
			case (ldState)
				LD_IDLE:
				begin
					if (loadWe)
						ldState <= LD_ACK;
				end
				LD_ACK:
				begin
					// Hold ack until request drops
					if (!loadReq)
						ldState <= LD_WAIT;
				end
				default:
					ldState <= LD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (loadWe)
			imem[loadAddr] <= loadData;
	end

	// Ack only ever answers a request from the previous edge
	assert property (@(posedge clk) disable iff (rst) $rose(loadAck) |-> $past(loadReq))
		else $error("loadAck rose with loadReq low");

	// --------------------------------------------------
	// PC and IF/ID register
	// --------------------------------------------------

	// Registered run gives the two cycle start
	always_ff @(posedge clk)
	begin
		if (rst)
			runF <= 1'b0;
		else
			runF <= run;
	end

	always_ff @(posedge clk)
	begin
		if (rst || !runF)
			pcF <= '0;
		else if (branchTaken)
			pcF <= branchTarget;
		else if (!stallF)
			pcF <= pcF + 1'b1;
	end

	// Zero word decodes as a bubble
	always_ff @(posedge clk)
	begin
		if (rst || !runF || branchTaken)
		begin
			instrD <= '0;
			pcPlus1D <= '0;
		end
		else if (!stallD)
		begin
			instrD <= imem[pcF];
			pcPlus1D <= pcF + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit import pipePkg::*;
(
	input  opcode_t op,
	input  funct_t  funct,
	output logic    regWrite,
	output logic    memToReg,
	output logic    memWrite,
	output logic    aluSrc,
	output logic    regDst,
	output logic    branch,
	output aluOp_t  aluOp
);

	always_comb
	begin
		// Everything off unless the code is known
		regWrite = 1'b0;
		memToReg = 1'b0;
		memWrite = 1'b0;
		aluSrc = 1'b0;
		regDst = 1'b0;
		branch = 1'b0;
		aluOp = ALU_ADD;
		case (op)
			OP_RTYPE:
			begin
				// rd destination, op from funct
				regDst = 1'b1;
				regWrite = 1'b1;
				case (funct)
					FN_ADD: aluOp = ALU_ADD;
					FN_SUB: aluOp = ALU_SUB;
					FN_AND: aluOp = ALU_AND;
					FN_OR: aluOp = ALU_OR;
					FN_SLT: aluOp = ALU_SLT;
					default:
					begin
						regDst = 1'b0;
						regWrite = 1'b0;
					end
				endcase
			end
			OP_ADDI:
			begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
			end
			OP_LW:
			begin
				// Address is base plus offset
				regWrite = 1'b1;
				memToReg = 1'b1;
				aluSrc = 1'b1;
			end
			OP_SW:
			begin
				memWrite = 1'b1;
				aluSrc = 1'b1;
			end
			// Compare done in decode
			OP_BEQ: branch = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* design/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile import pipePkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  regAddr_t ra1,
	input  regAddr_t ra2,
	input  regAddr_t wa,
	input  word_t    wd,
	input  logic     we,
	output word_t    rd1,
	output word_t    rd2
);

	localparam int Depth = 2 ** $bits(regAddr_t);

	word_t regs [0:Depth-1];

	// Register 0 never written
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < Depth; i++)
				regs[i] <= '0;
		end
		else if (we && wa != '0)
			regs[wa] <= wd;
	end

	// Zero reg, then same-cycle write, then array
	function automatic word_t readPort(input regAddr_t ra);
		if (ra == '0)
			return '0;
		else if (we && ra == wa)
			return wd;
		else
			return regs[ra];
	endfunction

	always_comb
	begin
		rd1 = readPort(ra1);
		rd2 = readPort(ra2);
	end

endmodule

`default_nettype wire

/* design/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit import pipePkg::*;
(
	input  word_t  a,
	input  word_t  b,
	input  aluOp_t op,
	output word_t  y
);

	always_comb
	begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR: y = a | b;
			// Signed compare, result 0 or 1
			ALU_SLT: y = word_t'($signed(a) < $signed(b));
			default: y = '0;
		endcase
	end

endmodule

`default_nettype wire

/* design/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import pipePkg::*;
(
	input  regAddr_t rsD,
	input  regAddr_t rtD,
	input  regAddr_t rsE,
	input  regAddr_t rtE,
	input  regAddr_t writeRegE,
	input  regAddr_t writeRegM,
	input  regAddr_t writeRegW,
	input  logic     branchD,
	input  logic     regWriteE,
	input  logic     memToRegE,
	input  logic     regWriteM,
	input  logic     memToRegM,
	input  logic     regWriteW,
	output logic     stallF,
	output logic     stallD,
	output logic     flushE,
	output logic     fwdAD,
	output logic     fwdBD,
	output fwd_t     fwdAE,
	output fwd_t     fwdBE
);

	logic lwStall;
	logic branchStall;

	// Youngest producer wins, MEM before WB
	function automatic fwd_t selectE(input regAddr_t src);
		if (src != '0 && regWriteM && src == writeRegM)
			return FWD_MEM;
		else if (src != '0 && regWriteW && src == writeRegW)
			return FWD_WB;
		else
			return FWD_NONE;
	endfunction

	// True when src is produced by the given stage
	function automatic logic hits(input regAddr_t src, input regAddr_t dst, input logic wr);
		return wr && dst != '0 && src == dst;
	endfunction

	always_comb
	begin
		fwdAE = selectE(rsE);
		fwdBE = selectE(rtE);
		// Branch compare only sees ALU results in MEM
		fwdAD = branchD && hits(rsD, writeRegM, regWriteM);
		fwdBD = branchD && hits(rtD, writeRegM, regWriteM);
		// Load in execute feeding decode
		lwStall = hits(rsD, writeRegE, memToRegE) || hits(rtD, writeRegE, memToRegE);
		// Branch sources still in flight
		branchStall = branchD && (hits(rsD, writeRegE, regWriteE)
			|| hits(rtD, writeRegE, regWriteE)
			|| hits(rsD, writeRegM, memToRegM)
			|| hits(rtD, writeRegM, memToRegM));
		stallF = lwStall || branchStall;
		stallD = lwStall || branchStall;
		flushE = lwStall || branchStall;
	end

	// No stage ever forwards into register 0
	always_comb
	begin
		assert ((fwdAE == FWD_NONE || rsE != '0) && (fwdBE == FWD_NONE || rtE != '0)
			&& (!fwdAD || rsD != '0) && (!fwdBD || rtD != '0))
			else $error("forwarding selected for register 0");
	end

endmodule

`default_nettype wire

/* design/dataMemory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defs.svh"

module dataMemory import pipePkg::*;
(
	input  logic             clk,
	input  logic             we,
	input  logic [`XLEN-1:0] addr,
	input  word_t            wdata,
	output word_t            rdata
);

	word_t mem [0:(1 << `DMEM_AW)-1];

	// Word store on the edge
	always_ff @(posedge clk)
	begin
		if (we)
			mem[addr[`DMEM_AW-1:0]] <= wdata;
	end

	// Combinational read for the MEM stage
	assign rdata = mem[addr[`DMEM_AW-1:0]];

	// Store address from execute must land inside the array
	assert property (@(posedge clk) we |-> (addr[`XLEN-1:`DMEM_AW] == '0))
		else $error("store address 0x%08h outside data memory", addr);

endmodule

`default_nettype wire

/* design/pipeCore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defs.svh"

module pipeCore import pipePkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     run,
	input  logic     loadReq,
	input  pc_t      loadAddr,
	input  word_t    loadData,
	output logic     loadAck,
	output logic     wbValid,
	output regAddr_t wbReg,
	output word_t    wbData
);

	// Hazard controls
	logic stallF, stallD, flushE, fwdAD, fwdBD;
	fwd_t fwdAE, fwdBE;
	// Decode
	word_t instrD, rd1D, rd2D, signImmD, cmpA, cmpB;
	pc_t pcPlus1D, branchTarget;
	logic regWriteD, memToRegD, memWriteD, aluSrcD, regDstD, branchD, branchTaken;
	aluOp_t aluOpD;
	// Execute
	logic regWriteE, memToRegE, memWriteE, aluSrcE, regDstE;
	aluOp_t aluOpE;
	regAddr_t rsE, rtE, rdE, writeRegE;
	word_t rd1E, rd2E, signImmE, srcAE, writeDataE, srcBE, aluOutE;
	// Memory and writeback
	logic regWriteM, memToRegM, memWriteM, regWriteW, memToRegW;
	regAddr_t writeRegM, writeRegW;
	word_t aluOutM, writeDataM, readDataM, aluOutW, readDataW, resultW;

	fetchUnit fetch_i (.clk, .rst, .run, .stallD, .branchTaken, .branchTarget, .stallF,
		.loadReq, .loadAddr, .loadData, .loadAck, .instrD, .pcPlus1D);

	// --------------------------------------------------
	// Decode
	// --------------------------------------------------
	controlUnit ctrl_i (.op(instrD[31:26]), .funct(instrD[5:0]), .regWrite(regWriteD),
		.memToReg(memToRegD), .memWrite(memWriteD), .aluSrc(aluSrcD), .regDst(regDstD),
		.branch(branchD), .aluOp(aluOpD));

	regFile regs_i (.clk, .rst, .ra1(instrD[25:21]), .ra2(instrD[20:16]), .wa(writeRegW),
		.wd(resultW), .we(regWriteW), .rd1(rd1D), .rd2(rd2D));

	assign signImmD = {{(`XLEN-16){instrD[15]}}, instrD[15:0]};
	// Equality on forwarded operands
	assign cmpA = fwdAD ? aluOutM : rd1D;
	assign cmpB = fwdBD ? aluOutM : rd2D;
	// No redirect while stalled on stale operands
	assign branchTaken = branchD && (cmpA == cmpB) && !stallD;
	assign branchTarget = pcPlus1D + signImmD[`IMEM_AW-1:0];

	// ID/EX with a bubble on flush
	always_ff @(posedge clk)
	begin
		if (rst || flushE)
		begin
			{regWriteE, memToRegE, memWriteE, aluSrcE, regDstE} <= '0;
			aluOpE <= ALU_ADD;
			{rsE, rtE, rdE} <= '0;
		end
		else
		begin
			{regWriteE, memToRegE, memWriteE} <= {regWriteD, memToRegD, memWriteD};
			{aluSrcE, regDstE} <= {aluSrcD, regDstD};
			aluOpE <= aluOpD;
			{rsE, rtE, rdE} <= {instrD[25:21], instrD[20:16], instrD[15:11]};
		end
		{rd1E, rd2E, signImmE} <= {rd1D, rd2D, signImmD};
	end

	// --------------------------------------------------
	// Execute
	// --------------------------------------------------
	assign writeRegE = regDstE ? rdE : rtE;

	always_comb
	begin
		case (fwdAE)
			FWD_MEM: srcAE = aluOutM;
			FWD_WB: srcAE = resultW;
			default: srcAE = rd1E;
		endcase
		case (fwdBE)
			FWD_MEM: writeDataE = aluOutM;
			FWD_WB: writeDataE = resultW;
			default: writeDataE = rd2E;
		endcase
	end

	assign srcBE = aluSrcE ? signImmE : writeDataE;

	aluUnit alu_i (.a(srcAE), .b(srcBE), .op(aluOpE), .y(aluOutE));

	// EX/MEM and MEM/WB
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			{regWriteM, memToRegM, memWriteM, writeRegM} <= '0;
			{regWriteW, memToRegW, writeRegW} <= '0;
		end
		else
		begin
			{regWriteM, memToRegM, memWriteM} <= {regWriteE, memToRegE, memWriteE};
			writeRegM <= writeRegE;
			{regWriteW, memToRegW, writeRegW} <= {regWriteM, memToRegM, writeRegM};
		end
		{aluOutM, writeDataM} <= {aluOutE, writeDataE};
		{aluOutW, readDataW} <= {aluOutM, readDataM};
	end

	dataMemory dmem_i (.clk, .we(memWriteM), .addr(aluOutM), .wdata(writeDataM),
		.rdata(readDataM));

	// --------------------------------------------------
	// Writeback and trace
	// --------------------------------------------------
	assign resultW = memToRegW ? readDataW : aluOutW;

	// Register 0 writes stay off the trace
	assign wbValid = regWriteW && (writeRegW != '0);
	assign wbReg = writeRegW;
	assign wbData = resultW;

	hazardUnit hazard_i (.rsD(instrD[25:21]), .rtD(instrD[20:16]), .rsE, .rtE, .writeRegE,
		.writeRegM, .writeRegW, .branchD, .regWriteE, .memToRegE, .regWriteM, .memToRegM,
		.regWriteW, .stallF, .stallD, .flushE, .fwdAD, .fwdBD, .fwdAE, .fwdBE);

endmodule

`default_nettype wire

/* dv/pipeTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defs.svh"

module pipeTb import pipePkg::*;
();

	localparam int ProgLen = 40;
	localparam int ResetCycles = 16;
	// Worst case per loaded word and per executed instruction
	localparam int LoadCycles = 12;
	localparam int WorstCpi = 6;
	localparam int WatchCycles = ResetCycles + ProgLen * (LoadCycles + WorstCpi) + 100;
	localparam int AckLimit = 4;

	typedef struct packed {
		regAddr_t rd;
		word_t data;
	} traceEntry_t;

	logic clk;
	logic rst;
	logic run;
	logic loadReq;
	pc_t loadAddr;
	word_t loadData;
	logic loadAck;
	logic wbValid;
	regAddr_t wbReg;
	word_t wbData;

	integer seed;
	word_t prog [0:ProgLen-1];
	traceEntry_t expQ [$];
	traceEntry_t gotEntry;
	int expCount;
	int seenCount;

	pipeCore dut_i (.clk, .rst, .run, .loadReq, .loadAddr, .loadData, .loadAck,
		.wbValid, .wbReg, .wbData);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// --------------------------------------------------
	// Encoders and failure reporting
	// --------------------------------------------------
	function automatic word_t encodeR(input regAddr_t rs, input regAddr_t rt,
		input regAddr_t rd, input funct_t fn);
		return {OP_RTYPE, rs, rt, rd, 5'b00000, fn};
	endfunction

	function automatic word_t encodeI(input opcode_t op, input regAddr_t rs,
		input regAddr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			stopRun($sformatf("ERR %s expected 0x%08h got 0x%08h", name, expected, actual));
	endtask

	// --------------------------------------------------
	// Random program over registers 0 to 7 and 16 data words
	// --------------------------------------------------
	task automatic genProgram();
		logic [31:0] rnd;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		regAddr_t lastDst;
		logic [3:0] addr;
		logic [15:0] written;
		int kind;
		int off;
		int shadowEnd;
		funct_t fn;
		lastDst = '0;
		written = '0;
		shadowEnd = 0;
		for (int i = 0; i < ProgLen - 1; i++)
		begin
			rnd = $random(seed);
			kind = int'(rnd[3:0]);
			rs = {2'b00, rnd[6:4]};
			rt = {2'b00, rnd[9:7]};
			rd = {2'b00, rnd[12:10]};
			addr = rnd[19:16];
			// Lean on the last result to hit the forwarding paths
			if (rnd[13])
				rs = lastDst;
			case (rnd[22:20] % 5)
				0: fn = FN_ADD;
				1: fn = FN_SUB;
				2: fn = FN_AND;
				3: fn = FN_OR;
				default: fn = FN_SLT;
			endcase
			if (kind < 6)
			begin
				prog[i] = encodeR(rs, rt, rd, fn);
				lastDst = rd;
			end
			else if (kind < 9)
			begin
				// Signed 8 bit immediate that is often negative
				prog[i] = encodeI(OP_ADDI, rs, rt, {{8{rnd[31]}}, rnd[31:24]});
				lastDst = rt;
			end
			else if (kind < 11 || written == '0)
			begin
				// Store data sometimes straight from the last result
				if (rnd[14])
					rt = lastDst;
				prog[i] = encodeI(OP_SW, '0, rt, {12'h000, addr});
				// Only stores that no branch can skip count as written
				if (i >= shadowEnd)
					written[addr] = 1'b1;
			end
			else if (kind < 13)
			begin
				// Only read words already stored
				while (!written[addr])
					addr = addr + 4'd1;
				prog[i] = encodeI(OP_LW, '0, rt, {12'h000, addr});
				lastDst = rt;
			end
			else
			begin
				off = 1 + int'(rnd[21:20]) % 3;
				if (i + 1 + off > ProgLen - 1)
					off = ProgLen - 2 - i;
				if (i + 1 + off > shadowEnd)
					shadowEnd = i + 1 + off;
				// Equal sources give a sure taken branch
				if (rnd[14])
					rt = rs;
				prog[i] = encodeI(OP_BEQ, rs, rt, off[15:0]);
			end
		end
		// Final self-loop
		prog[ProgLen-1] = encodeI(OP_BEQ, '0, '0, 16'hffff);
	endtask

	// Sequential execution with one trace entry per nonzero register write
	function automatic void isaModel();
		word_t regs [0:31];
		word_t mem [0:(1 << `DMEM_AW)-1];
		word_t ins;
		word_t a;
		word_t b;
		word_t imm;
		word_t ea;
		word_t res;
		regAddr_t dst;
		logic wr;
		logic done;
		int pc;
		int nextPc;
		traceEntry_t e;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < (1 << `DMEM_AW); i++)
			mem[i] = '0;
		pc = 0;
		done = 1'b0;
		while (!done && pc < ProgLen)
		begin
			ins = prog[pc];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			ea = a + imm;
			nextPc = pc + 1;
			dst = ins[20:16];
			wr = 1'b0;
			res = '0;
			case (ins[31:26])
				OP_RTYPE:
				begin
					dst = ins[15:11];
					wr = 1'b1;
					case (ins[5:0])
						FN_ADD: res = a + b;
						FN_SUB: res = a - b;
						FN_AND: res = a & b;
						FN_OR: res = a | b;
						FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr = 1'b0;
					endcase
				end
				OP_ADDI:
				begin
					res = ea;
					wr = 1'b1;
				end
				OP_LW:
				begin
					res = mem[ea[`DMEM_AW-1:0]];
					wr = 1'b1;
				end
				OP_SW: mem[ea[`DMEM_AW-1:0]] = b;
				OP_BEQ:
				begin
					// No delay slot so the target is relative to pc plus one
					if (a == b)
						nextPc = pc + 1 + int'($signed(ins[15:0]));
				end
				default: ;
			endcase
			if (wr && dst != '0)
			begin
				regs[dst] = res;
				e.rd = dst;
				e.data = res;
				expQ.push_back(e);
			end
			done = (nextPc == pc);
			pc = nextPc;
		end
	endfunction

	// --------------------------------------------------
	// Four-phase load of one instruction word
	// --------------------------------------------------
	task automatic loadWord(input pc_t addr, input word_t data);
		logic [31:0] rnd;
		int waited;
		rnd = $random(seed);
		@(negedge clk);
		checkValue("loadAck", 32'h0, 32'(loadAck));
		loadAddr = addr;
		loadData = data;
		loadReq = 1'b1;
		waited = 0;
		@(negedge clk);
		while (loadAck !== 1'b1)
		begin
			waited++;
			if (waited > AckLimit)
				stopRun($sformatf("No loadAck came for the load of word %0d", addr));
			@(negedge clk);
		end
		// Ack must stay up through a random hold
		repeat (rnd[1:0])
		begin
			@(negedge clk);
			checkValue("loadAck", 32'h1, 32'(loadAck));
		end
		loadReq = 1'b0;
		waited = 0;
		@(negedge clk);
		while (loadAck !== 1'b0)
		begin
			waited++;
			if (waited > AckLimit)
				stopRun($sformatf("loadAck stayed high after the request for word %0d", addr));
			@(negedge clk);
		end
	endtask

	// Trace compare on the falling edge where outputs are settled
	always @(negedge clk)
	begin
		if (wbValid === 1'b1)
		begin
			if (expQ.size() == 0)
				stopRun($sformatf("Unexpected write of r%0d with 0x%08h after the last entry",
					wbReg, wbData));
			else
			begin
				gotEntry = expQ.pop_front();
				checkValue("wbReg", 32'(gotEntry.rd), 32'(wbReg));
				checkValue("wbData", gotEntry.data, wbData);
				seenCount++;
			end
		end
	end

	// Watchdog sized from load time and worst case CPI
	initial
	begin
		repeat (WatchCycles) @(posedge clk);
		stopRun($sformatf("Watchdog expired after %0d cycles before the program finished",
			WatchCycles));
	end

	initial
	begin
		seed = 32'h059b_d5aa;
		rst = 1'b1;
		run = 1'b0;
		loadReq = 1'b0;
		loadAddr = '0;
		loadData = '0;
		seenCount = 0;
		genProgram();
		isaModel();
		expCount = expQ.size();
		repeat (ResetCycles) @(negedge clk);
		rst = 1'b0;
		// Program goes in while halted
		for (int i = 0; i < ProgLen; i++)
			loadWord(pc_t'(i), prog[i]);
		@(negedge clk);
		run = 1'b1;
		while (seenCount < expCount)
			@(posedge clk);
		// Self-loop must stay quiet
		repeat (30) @(posedge clk);
		$display("%0d instructions loaded, %0d trace writes checked", ProgLen, seenCount);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+design
design/pipePkg.sv
design/fetchUnit.sv
design/controlUnit.sv
design/regFile.sv
design/aluUnit.sv
design/hazardUnit.sv
design/dataMemory.sv
design/pipeCore.sv
dv/pipeTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
TOP ?= pipeTb
FILELIST ?= vlog.f
OBJDIR ?= obj_dir
LOG ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
